//--- compile.f
common/tpm_mgmt_pkg.sv
common/mgmt_state_if.sv
hierarchy/hierarchy_ctrl.sv
logic/op_state_ctrl.sv
logic/startup_decode.sv
logic/response_code_gen.sv
logic/tpm_mgmt_top.sv
verif/tb_tpm_mgmt.sv

//--- verif/tb_tpm_mgmt.sv
/*
 * Testbench for the TPM management block.
 * Inputs change on the rising clock edge and outputs are sampled on the falling edge.
 * Each Startup combination runs from its own reset, because only a reset leaves
 * the operational state. HierarchyControl requests are held for two key cycles.
 */
`default_nettype none

module tb_tpm_mgmt;
	timeunit 1ns;
	timeprecision 100ps;
	import tpm_mgmt_pkg::*;

	localparam int      TEST_STEPS      = 25;
	localparam int      WATCHDOG_CYCLES = 2 * 50 * TEST_STEPS;
	localparam int      WAIT_LIMIT      = 40;
	// Commands that the management block itself does not decode
	localparam cc_t     CC_GET_RANDOM   = 16'h017B;
	localparam handle_t RH_NULL         = 32'h4000_0007;

	logic          clock_i;
	logic          reset_n_i;
	logic          keystart_n_i;
	cc_t           tpm_cc_i;
	logic [32:0]   cmd_param_i;
	su_t           orderly_i;
	logic          initialized_i;
	handle_t       auth_hierarchy_i;
	rc_t           exec_rc_i;
	locality_t     locality_i;
	logic          nv_ph_enable_nv_i;
	logic          nv_sh_enable_i;
	logic          nv_eh_enable_i;
	op_state_e     op_state_o;
	startup_type_e startup_type_o;
	rc_t           tpm_rc_o;
	logic          ph_enable_o;
	logic          ph_enable_nv_o;
	logic          sh_enable_o;
	logic          eh_enable_o;
	su_t           shutdown_save_o;

	integer seed;
	int     pass_count;
	int     fail_count;
	int     fails_at_open;
	string  cur_test;
	// Expected hierarchy enables
	logic   exp_ph;
	logic   exp_phnv;
	logic   exp_sh;
	logic   exp_eh;

	tpm_mgmt_top UUT (.*);

	initial begin : clock_gen
		clock_i = 1'b0;
		forever #2 clock_i = ~clock_i;
	end

	//////////////////////////////////////////////////
	// Reference rules
	//////////////////////////////////////////////////

	// Startup table indexed by orderly state and startup parameter
	function automatic startup_type_e expected_type(input su_t orderly, input su_t su_param);
		case ({orderly == TPM_SU_STATE, su_param == TPM_SU_STATE})
			2'b11: return SU_RESUME;
			2'b10: return SU_RESTART;
			2'b01: return SU_INVALID;
			default: return SU_RESET;
		endcase
	endfunction

	function automatic hc_verdict_e judge_request(input handle_t auth, input handle_t target,
		input logic yes, input locality_t loc);
		if (loc != TPM_LOC_ZERO)
			return HC_NONE;
		if (auth == TPM_RH_PLATFORM) begin
			// Platform may never re-enable itself
			if (target == TPM_RH_PLATFORM)
				return yes ? HC_BAD_VALUE : HC_OK;
			if ((target == TPM_RH_ENDORSEMENT) || (target == TPM_RH_OWNER) ||
				(target == TPM_RH_PLATFORM_NV))
				return HC_OK;
			return HC_BAD_VALUE;
		end
		if ((auth == TPM_RH_OWNER) || (auth == TPM_RH_ENDORSEMENT))
			return ((target == auth) && !yes) ? HC_OK : HC_BAD_AUTH;
		return HC_NONE;
	endfunction

	//////////////////////////////////////////////////
	// Check helpers
	//////////////////////////////////////////////////

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) pass_count++;
		else begin
			fail_count++;
			$display("Error %s %s: expected %h, actual %h", cur_test, what, expected, actual);
		end
	endtask

	task automatic check_enables;
		check_value("ph_enable", exp_ph, ph_enable_o);
		check_value("ph_enable_nv", exp_phnv, ph_enable_nv_o);
		check_value("sh_enable", exp_sh, sh_enable_o);
		check_value("eh_enable", exp_eh, eh_enable_o);
	endtask

	task automatic check_reset_values;
		check_value("reset state", OP_POWER_OFF, op_state_o);
		check_value("reset startup type", SU_DONE, startup_type_o);
		check_value("reset rc", TPM_RC_SUCCESS, tpm_rc_o);
		check_value("reset save", TPM_SU_CLEAR, shutdown_save_o);
		exp_ph   = 1'b0;
		exp_phnv = 1'b0;
		exp_sh   = 1'b0;
		exp_eh   = 1'b0;
		check_enables();
	endtask

	// Polls on falling edges until the state shows up or the limit runs out
	task automatic wait_state(input op_state_e target);
		int cycles;
		cycles = 0;
		do begin
			@(negedge clock_i);
			cycles++;
		end while ((op_state_o != target) && (cycles < WAIT_LIMIT));
		if (op_state_o != target) begin
			fail_count++;
			$display("%s: the state machine did not reach %s within %0d cycles",
				cur_test, target.name(), WAIT_LIMIT);
		end
	endtask

	task automatic open_test(input string name);
		cur_test      = name;
		fails_at_open = fail_count;
	endtask

	task automatic close_test;
		$display("%-28s %s", cur_test, (fail_count == fails_at_open) ? "pass" : "fail");
	endtask

	//////////////////////////////////////////////////
	// Stimulus tasks
	//////////////////////////////////////////////////

	// Idles on a command outside the block with no hierarchy authorization and keeps the parameter
	task automatic drive_idle;
		tpm_cc_i         <= CC_GET_RANDOM;
		auth_hierarchy_i <= '0;
		locality_i       <= TPM_LOC_ZERO;
		exec_rc_i        <= $random(seed);
	endtask

	task automatic reset_to_init;
		@(posedge clock_i);
		reset_n_i     <= 1'b0;
		keystart_n_i  <= 1'b1;
		initialized_i <= 1'b0;
		cmd_param_i   <= '0;
		orderly_i     <= TPM_SU_CLEAR;
		drive_idle();
		repeat (2) @(posedge clock_i);
		reset_n_i <= 1'b1;
		// Without a key cycle nothing may move
		repeat (2) begin
			@(negedge clock_i);
			check_reset_values();
		end
		@(posedge clock_i);
		keystart_n_i <= 1'b0;
		@(negedge clock_i);
		check_reset_values();
		@(negedge clock_i);
		check_value("first key cycle state", OP_INIT, op_state_o);
		// A command other than Startup is refused in INIT
		@(negedge clock_i);
		check_value("init state", OP_INIT, op_state_o);
		check_value("init rc", TPM_RC_INITIALIZE, tpm_rc_o);
	endtask

	task automatic startup_case(input string name, input su_t orderly, input su_t su_param,
		input logic [2:0] nv);
		startup_type_e expected;
		open_test(name);
		reset_to_init();
		expected = expected_type(orderly, su_param);
		@(posedge clock_i);
		tpm_cc_i    <= TPM_CC_STARTUP;
		cmd_param_i <= {17'h0_5A5A, su_param};
		orderly_i   <= orderly;
		{nv_ph_enable_nv_i, nv_sh_enable_i, nv_eh_enable_i} <= nv;
		wait_state(OP_STARTUP);
		if (expected == SU_INVALID) begin
			wait_state(OP_INIT);
			check_value("startup type", expected, startup_type_o);
			check_value("startup rc", TPM_RC_VALUE, tpm_rc_o);
		end else begin
			@(posedge clock_i);
			initialized_i <= 1'b1;
			wait_state(OP_OPERATIONAL);
			check_value("startup type", expected, startup_type_o);
			check_value("startup rc", TPM_RC_SUCCESS, tpm_rc_o);
			exp_ph   = 1'b1;
			exp_phnv = (expected == SU_RESUME) ? nv[2] : 1'b1;
			exp_sh   = (expected == SU_RESUME) ? nv[1] : 1'b1;
			exp_eh   = (expected == SU_RESUME) ? nv[0] : 1'b1;
			check_enables();
			// The Startup still held is now a second Startup
			@(posedge clock_i);
			drive_idle();
			@(negedge clock_i);
			check_value("repeated startup rc", TPM_RC_INITIALIZE, tpm_rc_o);
		end
		close_test();
	endtask

	task automatic hierarchy_request(input string name, input handle_t auth,
		input handle_t target, input logic yes, input locality_t loc);
		hc_verdict_e verdict;
		rc_t         rc_random;
		rc_t         expected_rc;
		open_test(name);
		rc_random = $random(seed);
		verdict   = judge_request(auth, target, yes, loc);
		@(posedge clock_i);
		tpm_cc_i         <= TPM_CC_HIERARCHYCONTROL;
		auth_hierarchy_i <= auth;
		cmd_param_i      <= {target, yes};
		locality_i       <= loc;
		exec_rc_i        <= rc_random;
		// One key cycle to capture the request, one to judge it
		repeat (2) @(posedge clock_i);
		@(negedge clock_i);
		case (verdict)
			HC_OK:        expected_rc = TPM_RC_SUCCESS;
			HC_BAD_VALUE: expected_rc = TPM_RC_VALUE;
			HC_BAD_AUTH:  expected_rc = TPM_RC_AUTH_TYPE;
			default:      expected_rc = rc_random;
		endcase
		if (verdict == HC_OK) begin
			if (target == TPM_RH_PLATFORM)
				exp_ph = yes;
			if (target == TPM_RH_PLATFORM_NV)
				exp_phnv = yes;
			if (target == TPM_RH_OWNER)
				exp_sh = yes;
			if (target == TPM_RH_ENDORSEMENT)
				exp_eh = yes;
		end
		check_enables();
		check_value("hierarchy rc", expected_rc, tpm_rc_o);
		@(posedge clock_i);
		drive_idle();
		@(posedge clock_i);
		close_test();
	endtask

	// Response code of a command one clock after it is presented
	task automatic plain_command(input string name, input cc_t cc, input logic init);
		rc_t rc_random;
		rc_t expected_rc;
		open_test(name);
		rc_random = $random(seed);
		@(posedge clock_i);
		tpm_cc_i      <= cc;
		initialized_i <= init;
		exec_rc_i     <= rc_random;
		@(posedge clock_i);
		@(negedge clock_i);
		expected_rc = ((cc == TPM_CC_STARTUP) && init) ? TPM_RC_INITIALIZE : rc_random;
		check_value("command rc", expected_rc, tpm_rc_o);
		check_value("command state", OP_OPERATIONAL, op_state_o);
		@(posedge clock_i);
		drive_idle();
		close_test();
	endtask

	task automatic shutdown_round(input string name);
		su_t saved;
		open_test(name);
		saved = $random(seed);
		@(posedge clock_i);
		tpm_cc_i    <= TPM_CC_SHUTDOWN;
		cmd_param_i <= {17'h1_0000, saved};
		wait_state(OP_SHUTDOWN);
		wait_state(OP_OPERATIONAL);
		check_value("shutdown save", saved, shutdown_save_o);
		// The held command takes one more round before the idle command lands
		@(posedge clock_i);
		drive_idle();
		wait_state(OP_OPERATIONAL);
		check_value("shutdown save kept", saved, shutdown_save_o);
		close_test();
	endtask

	//////////////////////////////////////////////////
	// Sequence, watchdog and protocol assertions
	//////////////////////////////////////////////////

	initial begin : stimulus
		seed              = 92445;
		pass_count        = 0;
		fail_count        = 0;
		fails_at_open     = 0;
		cur_test          = "init";
		reset_n_i         <= 1'b0;
		keystart_n_i      <= 1'b1;
		tpm_cc_i          <= CC_GET_RANDOM;
		cmd_param_i       <= '0;
		orderly_i         <= TPM_SU_CLEAR;
		initialized_i     <= 1'b0;
		auth_hierarchy_i  <= '0;
		exec_rc_i         <= '0;
		locality_i        <= TPM_LOC_ZERO;
		nv_ph_enable_nv_i <= 1'b0;
		nv_sh_enable_i    <= 1'b0;
		nv_eh_enable_i    <= 1'b0;
		startup_case("startup clear/state", TPM_SU_CLEAR, TPM_SU_STATE, 3'b111);
		startup_case("startup state/state", TPM_SU_STATE, TPM_SU_STATE, 3'b010);
		startup_case("startup state/clear", TPM_SU_STATE, TPM_SU_CLEAR, 3'b000);
		startup_case("startup clear/clear", TPM_SU_CLEAR, TPM_SU_CLEAR, 3'b000);
		hierarchy_request("ph clears eh", TPM_RH_PLATFORM, TPM_RH_ENDORSEMENT, 0, TPM_LOC_ZERO);
		hierarchy_request("ph sets eh", TPM_RH_PLATFORM, TPM_RH_ENDORSEMENT, 1, TPM_LOC_ZERO);
		hierarchy_request("ph clears sh", TPM_RH_PLATFORM, TPM_RH_OWNER, 0, TPM_LOC_ZERO);
		hierarchy_request("ph sets sh", TPM_RH_PLATFORM, TPM_RH_OWNER, 1, TPM_LOC_ZERO);
		hierarchy_request("ph clears phnv", TPM_RH_PLATFORM, TPM_RH_PLATFORM_NV, 0, TPM_LOC_ZERO);
		hierarchy_request("ph sets phnv", TPM_RH_PLATFORM, TPM_RH_PLATFORM_NV, 1, TPM_LOC_ZERO);
		hierarchy_request("ph sets itself", TPM_RH_PLATFORM, TPM_RH_PLATFORM, 1, TPM_LOC_ZERO);
		hierarchy_request("ph bad target", TPM_RH_PLATFORM, RH_NULL, 0, TPM_LOC_ZERO);
		hierarchy_request("owner sets sh", TPM_RH_OWNER, TPM_RH_OWNER, 1, TPM_LOC_ZERO);
		hierarchy_request("owner clears eh", TPM_RH_OWNER, TPM_RH_ENDORSEMENT, 0, TPM_LOC_ZERO);
		hierarchy_request("owner clears sh", TPM_RH_OWNER, TPM_RH_OWNER, 0, TPM_LOC_ZERO);
		hierarchy_request("endorsement sets eh", TPM_RH_ENDORSEMENT, TPM_RH_ENDORSEMENT, 1,
			TPM_LOC_ZERO);
		hierarchy_request("endorsement clears sh", TPM_RH_ENDORSEMENT, TPM_RH_OWNER, 0,
			TPM_LOC_ZERO);
		hierarchy_request("endorsement clears eh", TPM_RH_ENDORSEMENT, TPM_RH_ENDORSEMENT, 0,
			TPM_LOC_ZERO);
		hierarchy_request("null authorization", RH_NULL, TPM_RH_OWNER, 0, TPM_LOC_ZERO);
		hierarchy_request("locality two", TPM_RH_PLATFORM, TPM_RH_ENDORSEMENT, 1, 8'h04);
		plain_command("other command", CC_GET_RANDOM, 1'b0);
		plain_command("other command again", CC_GET_RANDOM, 1'b1);
		plain_command("startup when initialized", TPM_CC_STARTUP, 1'b1);
		shutdown_round("shutdown");
		hierarchy_request("ph clears itself", TPM_RH_PLATFORM, TPM_RH_PLATFORM, 0, TPM_LOC_ZERO);
		$display("Checks passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clock_i);
		$display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("Test FAILED");
		$finish;
	end

	// Power-off always leaves on the first key cycle
	a_leave_power_off: assert property (@(posedge clock_i) disable iff (!reset_n_i)
		((op_state_o == OP_POWER_OFF) && !keystart_n_i) |=> (op_state_o == OP_INIT))
	else begin
		fail_count++;
		$display("Error %s state after power-off: expected OP_INIT, actual %s",
			cur_test, op_state_o.name());
	end

	// Shutdown lasts exactly one key cycle
	a_shutdown_return: assert property (@(posedge clock_i) disable iff (!reset_n_i)
		((op_state_o == OP_SHUTDOWN) && !keystart_n_i) |=> (op_state_o == OP_OPERATIONAL))
	else begin
		fail_count++;
		$display("Error %s state after shutdown: expected OP_OPERATIONAL, actual %s",
			cur_test, op_state_o.name());
	end

	a_no_key_no_step: assert property (@(posedge clock_i) disable iff (!reset_n_i)
		keystart_n_i |=> $stable(op_state_o))
	else begin
		fail_count++;
		$display("Error %s state without key cycle: expected %0d, actual %0d",
			cur_test, $past(op_state_o), op_state_o);
	end

endmodule

`default_nettype wire

//--- logic/tpm_mgmt_top.sv
/*
 * Management block of a discrete TPM, without self-test or failure mode.
 * State moves only on clock edges with keystart_n_i low, tpm_rc_o on every edge.
 * A command and its parameters must be held until op_state_o shows its effect,
 * HierarchyControl for at least two key cycles. There is no back-pressure.
 */
`default_nettype none

module tpm_mgmt_top (
	input  wire                         clock_i,
	input  wire                         reset_n_i,
	input  wire                         keystart_n_i,
	input  tpm_mgmt_pkg::cc_t           tpm_cc_i,
	input  wire [32:0]                  cmd_param_i,
	input  tpm_mgmt_pkg::su_t           orderly_i,
	input  wire                         initialized_i,
	input  tpm_mgmt_pkg::handle_t       auth_hierarchy_i,
	input  tpm_mgmt_pkg::rc_t           exec_rc_i,
	input  tpm_mgmt_pkg::locality_t     locality_i,
	input  wire                         nv_ph_enable_nv_i,
	input  wire                         nv_sh_enable_i,
	input  wire                         nv_eh_enable_i,
	output tpm_mgmt_pkg::op_state_e     op_state_o,
	output tpm_mgmt_pkg::startup_type_e startup_type_o,
	output tpm_mgmt_pkg::rc_t           tpm_rc_o,
	output logic                        ph_enable_o,
	output logic                        ph_enable_nv_o,
	output logic                        sh_enable_o,
	output logic                        eh_enable_o,
	output tpm_mgmt_pkg::su_t           shutdown_save_o
);
	import tpm_mgmt_pkg::*;

	// Verdict of the hierarchy block, consumed by the response code
	hc_verdict_e hc_verdict;

	mgmt_state_if state_if ();

	// The low half of the parameter carries TPM_SU for Startup and Shutdown
	op_state_ctrl u_op_state_ctrl (
		.clock_i          (clock_i),
		.reset_n_i        (reset_n_i),
		.keystart_n_i     (keystart_n_i),
		.tpm_cc_i         (tpm_cc_i),
		.initialized_i    (initialized_i),
		.shutdown_param_i (cmd_param_i[15:0]),
		.shutdown_save_o  (shutdown_save_o),
		.st               (state_if.op_ctrl)
	);

	startup_decode u_startup_decode (
		.clock_i         (clock_i),
		.reset_n_i       (reset_n_i),
		.keystart_n_i    (keystart_n_i),
		.startup_param_i (cmd_param_i[15:0]),
		.orderly_i       (orderly_i),
		.st              (state_if.startup)
	);

	// For HierarchyControl the target handle sits above the yes/no bit
	hierarchy_ctrl u_hierarchy_ctrl (
		.clock_i           (clock_i),
		.reset_n_i         (reset_n_i),
		.keystart_n_i      (keystart_n_i),
		.tpm_cc_i          (tpm_cc_i),
		.locality_i        (locality_i),
		.auth_hierarchy_i  (auth_hierarchy_i),
		.target_param_i    (cmd_param_i[32:1]),
		.yes_no_i          (cmd_param_i[0]),
		.nv_ph_enable_nv_i (nv_ph_enable_nv_i),
		.nv_sh_enable_i    (nv_sh_enable_i),
		.nv_eh_enable_i    (nv_eh_enable_i),
		.ph_enable_o       (ph_enable_o),
		.ph_enable_nv_o    (ph_enable_nv_o),
		.sh_enable_o       (sh_enable_o),
		.eh_enable_o       (eh_enable_o),
		.hc_verdict_o      (hc_verdict),
		.st                (state_if.hierarchy)
	);

	response_code_gen u_response_code_gen (
		.clock_i       (clock_i),
		.reset_n_i     (reset_n_i),
		.tpm_cc_i      (tpm_cc_i),
		.initialized_i (initialized_i),
		.exec_rc_i     (exec_rc_i),
		.hc_verdict_i  (hc_verdict),
		.tpm_rc_o      (tpm_rc_o),
		.st            (state_if.response)
	);

	assign op_state_o     = state_if.op_state;
	assign startup_type_o = state_if.startup_type;

endmodule

`default_nettype wire

//--- logic/response_code_gen.sv
/*
 * Response code for the command response buffer.
 * Registered one clock after its inputs and updated on every clock, not only
 * on key cycles. The old code is held when no rule applies.
 */
`default_nettype none

module response_code_gen (
	input  wire                       clock_i,
	input  wire                       reset_n_i,
	input  tpm_mgmt_pkg::cc_t         tpm_cc_i,
	input  wire                       initialized_i,
	input  tpm_mgmt_pkg::rc_t         exec_rc_i,
	input  tpm_mgmt_pkg::hc_verdict_e hc_verdict_i,
	output tpm_mgmt_pkg::rc_t         tpm_rc_o,
	mgmt_state_if.response            st
);
	import tpm_mgmt_pkg::*;

	rc_t rc_d;

	always_comb begin
		rc_d = tpm_rc_o;
		case (st.op_state)
			OP_INIT: begin
				// Nothing but Startup is accepted before initialization
				if (tpm_cc_i != TPM_CC_STARTUP) begin
					rc_d = TPM_RC_INITIALIZE;
				end
			end
			OP_STARTUP: begin
				if (st.su_conflict) begin
					rc_d = TPM_RC_VALUE;
				end
				// Completed initialization wins over a parameter error
				if (st.initialized) begin
					rc_d = TPM_RC_SUCCESS;
				end
			end
			OP_OPERATIONAL: begin
				// A second Startup after initialization is refused
				if ((tpm_cc_i == TPM_CC_STARTUP) && initialized_i) begin
					rc_d = TPM_RC_INITIALIZE;
				end else begin
					case (hc_verdict_i)
						HC_OK:        rc_d = TPM_RC_SUCCESS;
						HC_BAD_VALUE: rc_d = TPM_RC_VALUE;
						HC_BAD_AUTH:  rc_d = TPM_RC_AUTH_TYPE;
						default:      rc_d = exec_rc_i;
					endcase
				end
			end
			// Power-off and shutdown keep the last code
			default: rc_d = tpm_rc_o;
		endcase
	end

	always_ff @(posedge clock_i or negedge reset_n_i) begin
		if (!reset_n_i) begin
			tpm_rc_o <= TPM_RC_SUCCESS;
		end else begin
			tpm_rc_o <= rc_d;
		end
	end

endmodule

`default_nettype wire

//--- logic/startup_decode.sv
/*
 * Startup-type decision from the Startup parameter and the orderly flag.
 * Both inputs are captured on every key cycle, the type only in STARTUP.
 * Outside STARTUP the registered type keeps its last value.
 */
`default_nettype none

module startup_decode (
	input  wire               clock_i,
	input  wire               reset_n_i,
	input  wire               keystart_n_i,
	input  tpm_mgmt_pkg::su_t startup_param_i,
	input  tpm_mgmt_pkg::su_t orderly_i,
	mgmt_state_if.startup     st
);
	import tpm_mgmt_pkg::*;

	su_t           startup_q;
	su_t           orderly_q;
	startup_type_e type_q;
	startup_type_e type_d;
	// Set once STARTUP has been seen, watched by the assertion below
	logic          seen_startup_q;

	always_ff @(posedge clock_i or negedge reset_n_i) begin
		if (!reset_n_i) begin
			startup_q      <= TPM_SU_CLEAR;
			orderly_q      <= TPM_SU_CLEAR;
			type_q         <= SU_DONE;
			seen_startup_q <= 1'b0;
		end else begin
			if (st.op_state == OP_STARTUP) begin
				seen_startup_q <= 1'b1;
			end
			if (!keystart_n_i) begin
				startup_q <= startup_param_i;
				orderly_q <= orderly_i;
				if (st.op_state == OP_STARTUP) begin
					type_q <= type_d;
				end
			end
		end
	end

	// Resume after a disorderly shutdown cannot be honoured
	assign st.su_conflict = (startup_q == TPM_SU_STATE) && (orderly_q == TPM_SU_CLEAR);

	always_comb begin
		type_d = SU_DONE;
		if (st.op_state == OP_STARTUP) begin
			if ((orderly_q == TPM_SU_STATE) && (startup_q == TPM_SU_STATE)) begin
				type_d = SU_RESUME;
			end else if ((orderly_q == TPM_SU_STATE) && (startup_q == TPM_SU_CLEAR)) begin
				type_d = SU_RESTART;
			end else if (st.su_conflict) begin
				type_d = SU_INVALID;
			end else begin
				type_d = SU_RESET;
			end
		end
	end

	assign st.startup_type = type_q;

	a_done_before_startup: assert property (@(posedge clock_i) disable iff (!reset_n_i)
		!seen_startup_q |-> (type_q == SU_DONE));

endmodule

`default_nettype wire

//--- logic/op_state_ctrl.sv
/*
 * Operational-state machine of the TPM management block.
 * Takes exactly one step per key cycle. The startup type and the latched
 * init flag it reads are registered, so STARTUP lasts at least two key cycles.
 */
`default_nettype none

module op_state_ctrl (
	input  wire                   clock_i,
	input  wire                   reset_n_i,
	input  wire                   keystart_n_i,
	input  tpm_mgmt_pkg::cc_t     tpm_cc_i,
	input  wire                   initialized_i,
	input  tpm_mgmt_pkg::su_t     shutdown_param_i,
	output tpm_mgmt_pkg::su_t     shutdown_save_o,
	mgmt_state_if.op_ctrl         st
);
	import tpm_mgmt_pkg::*;

	op_state_e state_q;
	op_state_e state_d;
	logic      initialized_q;

	//////////////////////////////////////////////////
	// Next state
	//////////////////////////////////////////////////

	always_comb begin
		state_d = state_q;
		case (state_q)
			// Power-off always falls through to initialization
			OP_POWER_OFF: state_d = OP_INIT;
			OP_INIT: begin
				// Only Startup leaves initialization
				if (tpm_cc_i == TPM_CC_STARTUP) begin
					state_d = OP_STARTUP;
				end
			end
			OP_STARTUP: begin
				// The execution engine reports completion through the latched flag
				if (initialized_q) begin
					state_d = OP_OPERATIONAL;
				end else if (st.startup_type == SU_INVALID) begin
					// A bad parameter pairing makes the root of trust retry Startup
					state_d = OP_INIT;
				end
			end
			OP_OPERATIONAL: begin
				if (tpm_cc_i == TPM_CC_SHUTDOWN) begin
					state_d = OP_SHUTDOWN;
				end
			end
			OP_SHUTDOWN: state_d = OP_OPERATIONAL;
			default: state_d = OP_POWER_OFF;
		endcase
	end

	//////////////////////////////////////////////////
	// Registers
	//////////////////////////////////////////////////

	always_ff @(posedge clock_i or negedge reset_n_i) begin
		if (!reset_n_i) begin
			state_q         <= OP_POWER_OFF;
			initialized_q   <= 1'b0;
			shutdown_save_o <= TPM_SU_CLEAR;
		end else if (!keystart_n_i) begin
			state_q <= state_d;
			// The init flag is sampled only while startup is running
			if (state_q == OP_STARTUP) begin
				initialized_q <= initialized_i;
			end
			// Shutdown type is kept for the next orderly check
			if (state_q == OP_SHUTDOWN) begin
				shutdown_save_o <= shutdown_param_i;
			end
		end
	end

	assign st.op_state    = state_q;
	assign st.initialized = initialized_q;

	// The unused encodings 4, 5 and 7 must never be reached
	a_state_legal: assert property (@(posedge clock_i) disable iff (!reset_n_i)
		state_q inside {OP_POWER_OFF, OP_INIT, OP_STARTUP, OP_OPERATIONAL, OP_SHUTDOWN});

endmodule

`default_nettype wire

//--- hierarchy/hierarchy_ctrl.sv
/*
 * Hierarchy enables and the HierarchyControl authorization rules.
 * Request fields are captured on a key cycle in OPERATIONAL and judged on the
 * next one, so the command must be held for two key cycles.
 * Only locality zero is served, other localities see no verdict.
 */
`default_nettype none

module hierarchy_ctrl (
	input  wire                       clock_i,
	input  wire                       reset_n_i,
	input  wire                       keystart_n_i,
	input  tpm_mgmt_pkg::cc_t         tpm_cc_i,
	input  tpm_mgmt_pkg::locality_t   locality_i,
	input  tpm_mgmt_pkg::handle_t     auth_hierarchy_i,
	input  tpm_mgmt_pkg::handle_t     target_param_i,
	input  wire                       yes_no_i,
	input  wire                       nv_ph_enable_nv_i,
	input  wire                       nv_sh_enable_i,
	input  wire                       nv_eh_enable_i,
	output logic                      ph_enable_o,
	output logic                      ph_enable_nv_o,
	output logic                      sh_enable_o,
	output logic                      eh_enable_o,
	output tpm_mgmt_pkg::hc_verdict_e hc_verdict_o,
	mgmt_state_if.hierarchy           st
);
	import tpm_mgmt_pkg::*;

	handle_t auth_q;
	handle_t target_q;
	logic    yes_no_q;
	logic    startup_load;
	logic    hc_request;

	// The load runs only once the type has been decided and is usable
	assign startup_load = (st.op_state == OP_STARTUP) &&
		(st.startup_type != SU_DONE) && (st.startup_type != SU_INVALID);

	assign hc_request = (st.op_state == OP_OPERATIONAL) &&
		(tpm_cc_i == TPM_CC_HIERARCHYCONTROL) && (locality_i == TPM_LOC_ZERO);

	//////////////////////////////////////////////////
	// Authorization rules
	//////////////////////////////////////////////////

	always_comb begin
		hc_verdict_o = HC_NONE;
		if (hc_request) begin
			case (auth_q)
				TPM_RH_PLATFORM: begin
					// Platform may switch the others either way but only drop itself
					if ((target_q == TPM_RH_ENDORSEMENT) || (target_q == TPM_RH_OWNER) ||
						(target_q == TPM_RH_PLATFORM_NV) ||
						((target_q == TPM_RH_PLATFORM) && !yes_no_q)) begin
						hc_verdict_o = HC_OK;
					end else begin
						hc_verdict_o = HC_BAD_VALUE;
					end
				end
				TPM_RH_OWNER: begin
					hc_verdict_o = ((target_q == TPM_RH_OWNER) && !yes_no_q) ?
						HC_OK : HC_BAD_AUTH;
				end
				TPM_RH_ENDORSEMENT: begin
					hc_verdict_o = ((target_q == TPM_RH_ENDORSEMENT) && !yes_no_q) ?
						HC_OK : HC_BAD_AUTH;
				end
				// Any other authorization is left to the execution engine
				default: hc_verdict_o = HC_NONE;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Capture and enables
	//////////////////////////////////////////////////

	always_ff @(posedge clock_i or negedge reset_n_i) begin
		if (!reset_n_i) begin
			auth_q         <= '0;
			target_q       <= '0;
			yes_no_q       <= 1'b0;
			ph_enable_o    <= 1'b0;
			ph_enable_nv_o <= 1'b0;
			sh_enable_o    <= 1'b0;
			eh_enable_o    <= 1'b0;
		end else if (!keystart_n_i) begin
			if (startup_load) begin
				// Platform is always enabled after any startup
				ph_enable_o <= 1'b1;
				if (st.startup_type == SU_RESUME) begin
					ph_enable_nv_o <= nv_ph_enable_nv_i;
					sh_enable_o    <= nv_sh_enable_i;
					eh_enable_o    <= nv_eh_enable_i;
				end else begin
					ph_enable_nv_o <= 1'b1;
					sh_enable_o    <= 1'b1;
					eh_enable_o    <= 1'b1;
				end
			end else if (st.op_state == OP_OPERATIONAL) begin
				auth_q   <= auth_hierarchy_i;
				target_q <= target_param_i;
				yes_no_q <= yes_no_i;
				if (hc_verdict_o == HC_OK) begin
					case (target_q)
						TPM_RH_ENDORSEMENT: eh_enable_o    <= yes_no_q;
						TPM_RH_OWNER:       sh_enable_o    <= yes_no_q;
						TPM_RH_PLATFORM_NV: ph_enable_nv_o <= yes_no_q;
						TPM_RH_PLATFORM:    ph_enable_o    <= yes_no_q;
						default:            ph_enable_o    <= ph_enable_o;
					endcase
				end
			end
		end
	end

	// Only a startup load may turn the platform hierarchy back on
	a_ph_no_rise_op: assert property (@(posedge clock_i) disable iff (!reset_n_i)
		$rose(ph_enable_o) |-> ($past(st.op_state) != OP_OPERATIONAL));

endmodule

`default_nettype wire

//--- common/mgmt_state_if.sv
/*
 * State view shared by the management control modules.
 * Carries no clock, every signal is registered by its driver.
 */
`default_nettype none

interface mgmt_state_if;
	import tpm_mgmt_pkg::*;

	op_state_e     op_state;
	logic          initialized;
	startup_type_e startup_type;
	logic          su_conflict;

	// The state machine owns the state and the latched init flag
	modport op_ctrl (output op_state, output initialized, input startup_type);
	// Startup decode owns the type and the parameter conflict
	modport startup (input op_state, output startup_type, output su_conflict);
	modport hierarchy (input op_state, input startup_type);
	modport response (input op_state, input initialized, input su_conflict);

endinterface

`default_nettype wire

//--- common/tpm_mgmt_pkg.sv
/*
 * Shared codes and types for the TPM management block.
 * Command, response and handle values follow the TPM 2.0 library encodings.
 * Self-test and failure mode are not supported, so their codes are absent.
 * Enum encodings are visible on the top-level state outputs.
 */
`default_nettype none

package tpm_mgmt_pkg;

	//////////////////////////////////////////////////
	// Vector types
	//////////////////////////////////////////////////

	// Command code as presented by the command buffer
	typedef logic [15:0] cc_t;
	// Full response code returned to the response buffer
	typedef logic [31:0] rc_t;
	// Permanent hierarchy handle
	typedef logic [31:0] handle_t;
	// One-hot locality of the current command
	typedef logic [7:0]  locality_t;
	// TPM_SU value used by Startup, Shutdown and the orderly flag
	typedef logic [15:0] su_t;

	//////////////////////////////////////////////////
	// State machine and decision types
	//////////////////////////////////////////////////

	// Operational state with codes 4 and 5 left unused
	typedef enum logic [2:0] {
		OP_POWER_OFF   = 3'd0,
		OP_INIT        = 3'd1,
		OP_STARTUP     = 3'd2,
		OP_OPERATIONAL = 3'd3,
		OP_SHUTDOWN    = 3'd6
	} op_state_e;

	// Startup type reported to the execution engine
	typedef enum logic [2:0] {
		SU_DONE    = 3'd0,
		SU_RESET   = 3'd1,
		SU_RESTART = 3'd2,
		SU_RESUME  = 3'd3,
		SU_INVALID = 3'd4
	} startup_type_e;

	// Outcome of a HierarchyControl request
	typedef enum logic [1:0] {
		HC_NONE      = 2'd0,
		HC_OK        = 2'd1,
		HC_BAD_VALUE = 2'd2,
		HC_BAD_AUTH  = 2'd3
	} hc_verdict_e;

	//////////////////////////////////////////////////
	// Code values
	//////////////////////////////////////////////////

	localparam cc_t TPM_CC_HIERARCHYCONTROL = 16'h0121;
	localparam cc_t TPM_CC_STARTUP          = 16'h0144;
	localparam cc_t TPM_CC_SHUTDOWN         = 16'h0145;

	// INITIALIZE and AUTH_TYPE are format 0, VALUE is format 1
	localparam rc_t TPM_RC_SUCCESS    = 32'h0000_0000;
	localparam rc_t TPM_RC_INITIALIZE = 32'h0000_0100;
	localparam rc_t TPM_RC_AUTH_TYPE  = 32'h0000_0124;
	localparam rc_t TPM_RC_VALUE      = 32'h0000_0084;

	localparam su_t TPM_SU_CLEAR = 16'h0000;
	localparam su_t TPM_SU_STATE = 16'h0001;

	localparam handle_t TPM_RH_OWNER       = 32'h4000_0001;
	localparam handle_t TPM_RH_ENDORSEMENT = 32'h4000_000B;
	localparam handle_t TPM_RH_PLATFORM    = 32'h4000_000C;
	localparam handle_t TPM_RH_PLATFORM_NV = 32'h4000_000D;

	// Only locality zero may run HierarchyControl
	localparam locality_t TPM_LOC_ZERO = 8'b0000_0001;

endpackage

`default_nettype wire
